//--- logic/dlx_settings.svh
`ifndef DLX_SETTINGS_SVH
`define DLX_SETTINGS_SVH

// datapath and address width
`define DLX_XLEN        32
// architectural registers, r0 hardwired to zero
`define DLX_NUM_REGS    32
// first fetch address out of reset
`define DLX_RESET_PC    32'h0000_0000

// opcodes in instr[31:26]
`define DLX_OP_RTYPE    6'h00
`define DLX_OP_ADDI     6'h08
`define DLX_OP_ANDI     6'h0c
`define DLX_OP_ORI      6'h0d
`define DLX_OP_XORI     6'h0e
`define DLX_OP_LW       6'h23
`define DLX_OP_SW       6'h2b

// r-type function codes in instr[5:0]
`define DLX_FN_ADD      6'h20
`define DLX_FN_SUB      6'h22
`define DLX_FN_AND      6'h24
`define DLX_FN_OR       6'h25
`define DLX_FN_XOR      6'h26
`define DLX_FN_SLL      6'h04
`define DLX_FN_SRL      6'h06
`define DLX_FN_SLT      6'h2a

`endif

//--- logic/dlx_pkg.sv
`include "dlx_settings.svh"

package dlx_pkg;

    // one data or address word
    typedef logic [`DLX_XLEN-1:0] word_t;
    // register number
    typedef logic [$clog2(`DLX_NUM_REGS)-1:0] reg_idx_t;

    // alu operations, add first so a bubble decodes as add
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_t;

    ////////////////////////////////////////
    // stage payloads, all zero is a bubble
    ////////////////////////////////////////

    typedef struct packed {
        word_t instr;
        word_t pc;
    } if_id_t;

    typedef struct packed {
        alu_op_t  alu_op;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        logic     use_imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t rd;
        logic     reg_write;
    } mem_wb_t;

endpackage

//--- logic/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    // keep current contents
    input  logic     hold,
    // load an all-zero payload
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // bubble wins over hold so a stalled stage can be emptied
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- logic/front_end.sv
`timescale 1ns/1ps
`include "dlx_settings.svh"

module front_end import dlx_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    output word_t    imem_addr,
    input  word_t    imem_data,
    input  if_id_t   if_id,
    output if_id_t   fetch,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    output id_ex_t   decoded
);

    word_t      pc;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       valid;

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////

    // pc holds for one clock on a load-use stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `DLX_RESET_PC;
        end else if (!stall) begin
            pc <= pc + word_t'(4);
        end
    end

    assign imem_addr   = pc;
    assign fetch.pc    = pc;
    assign fetch.instr = imem_data;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    assign opcode = if_id.instr[31:26];
    assign funct  = if_id.instr[5:0];
    // source fields go straight to the register file
    assign rs1    = if_id.instr[25:21];
    assign rs2    = if_id.instr[20:16];

    always_comb begin
        decoded         = '0;
        valid           = 1'b1;
        decoded.rs1     = rs1;
        decoded.rs2     = rs2;
        decoded.rs1_val = rs1_val;
        decoded.rs2_val = rs2_val;
        // i-type default, rt is the destination
        decoded.rd        = if_id.instr[20:16];
        decoded.reg_write = 1'b1;
        decoded.use_imm   = 1'b1;
        decoded.imm       = word_t'(if_id.instr[15:0]);
        case (opcode)
            `DLX_OP_RTYPE: begin
                decoded.rd      = if_id.instr[15:11];
                decoded.use_imm = 1'b0;
                case (funct)
                    `DLX_FN_ADD: decoded.alu_op = ALU_ADD;
                    `DLX_FN_SUB: decoded.alu_op = ALU_SUB;
                    `DLX_FN_AND: decoded.alu_op = ALU_AND;
                    `DLX_FN_OR:  decoded.alu_op = ALU_OR;
                    `DLX_FN_XOR: decoded.alu_op = ALU_XOR;
                    `DLX_FN_SLL: decoded.alu_op = ALU_SLL;
                    `DLX_FN_SRL: decoded.alu_op = ALU_SRL;
                    `DLX_FN_SLT: decoded.alu_op = ALU_SLT;
                    default:     valid = 1'b0;
                endcase
            end
            // address and addi immediates are signed
            `DLX_OP_ADDI: decoded.imm = word_t'($signed(if_id.instr[15:0]));
            `DLX_OP_ANDI: decoded.alu_op = ALU_AND;
            `DLX_OP_ORI:  decoded.alu_op = ALU_OR;
            `DLX_OP_XORI: decoded.alu_op = ALU_XOR;
            `DLX_OP_LW: begin
                decoded.imm      = word_t'($signed(if_id.instr[15:0]));
                decoded.mem_read = 1'b1;
            end
            `DLX_OP_SW: begin
                decoded.imm       = word_t'($signed(if_id.instr[15:0]));
                decoded.rd        = '0;
                decoded.reg_write = 1'b0;
                decoded.mem_write = 1'b1;
            end
            default: valid = 1'b0;
        endcase
        // anything unrecognised runs as a no-op
        if (!valid) begin
            decoded = '0;
        end
    end

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps
`include "dlx_settings.svh"

module register_file import dlx_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_val,
    output word_t    rs2_val,
    input  reg_idx_t wb_rd,
    input  word_t    wb_value,
    input  logic     wb_we
);

    word_t regs [`DLX_NUM_REGS];

    // r0 is never written, stays at its reset value of zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DLX_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_value;
        end
    end

    // writeback bypass so decode sees the value written this cycle
    assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_value : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_value : regs[rs2];

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import dlx_pkg::*; (
    // sources of the instruction in decode
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  logic     id_uses_rs2,
    // instruction in execute
    input  id_ex_t   ex,
    // producers further down the pipe
    input  reg_idx_t mem_rd,
    input  logic     mem_we,
    input  reg_idx_t wb_rd,
    input  logic     wb_we,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b,
    output logic     stall
);

    logic ld_hit_rs1;
    logic ld_hit_rs2;

    // memory stage is younger than writeback and wins
    function automatic fwd_sel_t pick_fwd(reg_idx_t src);
        if (src == '0) return FWD_REG;
        if (mem_we && mem_rd == src) return FWD_MEM;
        if (wb_we && wb_rd == src) return FWD_WB;
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a = pick_fwd(ex.rs1);
        fwd_b = pick_fwd(ex.rs2);
    end

    ////////////////////////////////////////
    // load-use detection
    ////////////////////////////////////////

    // load data only exists from the memory stage on so one bubble is needed
    assign ld_hit_rs1 = ex.rd == id_rs1;
    assign ld_hit_rs2 = id_uses_rs2 && ex.rd == id_rs2;
    assign stall      = ex.mem_read && ex.rd != '0 && (ld_hit_rs1 || ld_hit_rs2);

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import dlx_pkg::*; (
    input  id_ex_t   ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    // alu result sitting in EX/MEM
    input  word_t    mem_value,
    // value on the writeback bus
    input  word_t    wb_value,
    output ex_mem_t  result
);

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_out;

    // operand forwarding
    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = mem_value;
            FWD_WB:  op_a = wb_value;
            default: op_a = ex.rs1_val;
        endcase
        case (fwd_b)
            FWD_MEM: op_b_reg = mem_value;
            FWD_WB:  op_b_reg = wb_value;
            default: op_b_reg = ex.rs2_val;
        endcase
    end

    assign op_b = ex.use_imm ? ex.imm : op_b_reg;

    // shifts take the low five bits of b
    always_comb begin
        case (ex.alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLL: alu_out = op_a << op_b[4:0];
            ALU_SRL: alu_out = op_a >> op_b[4:0];
            ALU_SLT: alu_out = word_t'($signed(op_a) < $signed(op_b));
            default: alu_out = op_a + op_b;
        endcase
    end

    // store data is the forwarded rt, never the immediate
    assign result.alu_result = alu_out;
    assign result.store_data = op_b_reg;
    assign result.rd         = ex.rd;
    assign result.reg_write  = ex.reg_write;
    assign result.mem_read   = ex.mem_read;
    assign result.mem_write  = ex.mem_write;

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import dlx_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  ex_mem_t  mem,
    output word_t    dmem_addr,
    output word_t    dmem_wdata,
    output logic     dmem_we,
    input  word_t    dmem_rdata,
    output reg_idx_t wb_rd,
    output word_t    wb_value,
    output logic     wb_we
);

    mem_wb_t wb_d;
    mem_wb_t wb_q;

    // data port straight from EX/MEM, read data back in the same cycle
    assign dmem_addr  = mem.alu_result;
    assign dmem_wdata = mem.store_data;
    assign dmem_we    = mem.mem_write;

    // loads take the memory word, everything else the alu result
    assign wb_d.result    = mem.mem_read ? dmem_rdata : mem.alu_result;
    assign wb_d.rd        = mem.rd;
    assign wb_d.reg_write = mem.reg_write;

    pipe_stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (wb_d),
        .q      (wb_q)
    );

    // writeback bus, shared by register file and execute
    assign wb_rd    = wb_q.rd;
    assign wb_value = wb_q.result;
    assign wb_we    = wb_q.reg_write;

endmodule

//--- logic/dlx_core.sv
`timescale 1ns/1ps

module dlx_core import dlx_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);

    // stage payloads, d side and q side of each register
    if_id_t   fetch;
    if_id_t   if_id_q;
    id_ex_t   decoded;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_result;
    ex_mem_t  ex_mem_q;
    // decode register reads
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_val;
    word_t    rs2_val;
    // hazard control
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     stall;
    // writeback bus
    reg_idx_t wb_rd;
    word_t    wb_value;
    logic     wb_we;

    ////////////////////////////////////////
    // fetch and decode
    ////////////////////////////////////////

    front_end front_end_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_id     (if_id_q),
        .fetch     (fetch),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .decoded   (decoded)
    );

    // stalled instruction waits in IF/ID
    pipe_stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (stall),
        .bubble (1'b0),
        .d      (fetch),
        .q      (if_id_q)
    );

    register_file register_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wb_rd    (wb_rd),
        .wb_value (wb_value),
        .wb_we    (wb_we)
    );

    // rt is a source for r-type and sw only
    hazard_unit hazard_unit_inst (
        .id_rs1      (rs1),
        .id_rs2      (rs2),
        .id_uses_rs2 (decoded.mem_write | (decoded.reg_write & ~decoded.use_imm)),
        .ex          (id_ex_q),
        .mem_rd      (ex_mem_q.rd),
        .mem_we      (ex_mem_q.reg_write),
        .wb_rd       (wb_rd),
        .wb_we       (wb_we),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .stall       (stall)
    );

    ////////////////////////////////////////
    // execute, memory, writeback
    ////////////////////////////////////////

    // bubble goes into execute behind a load
    pipe_stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (1'b0),
        .bubble (stall),
        .d      (decoded),
        .q      (id_ex_q)
    );

    execute_unit execute_unit_inst (
        .ex        (id_ex_q),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .mem_value (ex_mem_q.alu_result),
        .wb_value  (wb_value),
        .result    (ex_result)
    );

    pipe_stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (ex_result),
        .q      (ex_mem_q)
    );

    memory_stage memory_stage_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem        (ex_mem_q),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .wb_rd      (wb_rd),
        .wb_value   (wb_value),
        .wb_we      (wb_we)
    );

endmodule

//--- verif/dlx_core_assert.sv
`timescale 1ns/1ps

module dlx_core_assert import dlx_pkg::*; (
    input logic  clk,
    input logic  arst_n,
    input word_t imem_addr,
    input word_t dmem_addr,
    input logic  dmem_we
);

    // write enable must always be known once out of reset
    we_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(dmem_we))
        else $error("dmem_we is unknown");

    // data port is word addressed
    addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> dmem_addr[1:0] == 2'b00)
        else $error("unaligned data write");

    // fetch only steps forward or holds for a stall
    pc_step: assert property (@(posedge clk) disable iff (!arst_n)
        imem_addr == $past(imem_addr) + 32'd4 || imem_addr == $past(imem_addr))
        else $error("imem_addr jumped");

endmodule

//--- verif/dlx_core_tb.sv
`timescale 1ns/1ps
`include "dlx_settings.svh"

module dlx_core_tb import dlx_pkg::*; ();

    localparam int PROG_LEN    = 200;
    localparam int NUM_DUMP    = 31;
    localparam int TOTAL       = PROG_LEN + NUM_DUMP;
    localparam int CYCLE_LIMIT = 2 * TOTAL + 100;
    localparam int IMEM_WORDS  = 1024;
    localparam int DMEM_WORDS  = 64;

    logic  clk;
    logic  arst_n;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    logic [31:0] lfsr_state;
    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t model_dmem [DMEM_WORDS];
    word_t model_regs [32];
    // expected data writes, in program order
    word_t exp_addr [$];
    word_t exp_data [$];
    int    exp_src [$];
    word_t exp_trace [$];
    word_t trace [$];
    int    n_prog_stores;
    int    n_pred_stalls;
    int    stores_seen;
    int    total_stores;
    int    cycles;
    int    reset_errs;
    int    store_errs;
    int    lu_errs;
    int    trace_errs;
    int    r0_errs;
    int    dump_errs;
    logic  timed_out;

    dlx_core dlx_core_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    bind dlx_core dlx_core_assert dlx_core_assert_inst (.*);

    // combinational memory ports
    assign imem_data  = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial cycles = 0;
    always @(posedge clk) cycles <= cycles + 1;

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t enc_r(logic [5:0] fn, logic [4:0] rd, logic [4:0] ra,
                                    logic [4:0] rb);
        return {`DLX_OP_RTYPE, ra, rb, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
                                    logic [15:0] imm);
        return {op, ra, rt, imm};
    endfunction

    task automatic gen_program();
        logic [5:0] fn_tab [8];
        logic [5:0] op_tab [4];
        logic [3:0] kind;
        logic [2:0] sel;
        logic [4:0] rd;
        logic [4:0] ra;
        logic [4:0] rb;
        logic [5:0] off;
        fn_tab = '{`DLX_FN_ADD, `DLX_FN_SUB, `DLX_FN_AND, `DLX_FN_OR,
                   `DLX_FN_XOR, `DLX_FN_SLL, `DLX_FN_SRL, `DLX_FN_SLT};
        op_tab = '{`DLX_OP_ADDI, `DLX_OP_ANDI, `DLX_OP_ORI, `DLX_OP_XORI};
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = 4'(rand_bits(4));
            // r0..r7 only, keeps dependencies dense
            rd = 5'(rand_bits(3));
            ra = 5'(rand_bits(3));
            rb = 5'(rand_bits(3));
            if (kind < 4'd8) begin
                sel = 3'(rand_bits(3));
                imem[i] = enc_r(fn_tab[sel], rd, ra, rb);
            end else if (kind < 4'd12) begin
                imem[i] = enc_i(op_tab[kind[1:0]], rb, ra, 16'(rand_bits(16)));
            end else begin
                off = 6'(rand_bits(6));
                imem[i] = enc_i(kind < 4'd14 ? `DLX_OP_LW : `DLX_OP_SW, rb, 5'd0,
                                {8'd0, off, 2'b00});
            end
        end
        // register dump above the data window
        for (int r = 1; r <= NUM_DUMP; r++) begin
            imem[PROG_LEN + r - 1] = enc_i(`DLX_OP_SW, 5'(r), 5'd0, 16'(256 + 4 * (r - 1)));
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]       = rand_bits(32);
            model_dmem[i] = dmem[i];
        end
    endtask

    ////////////////////////////////////////
    // isa model
    ////////////////////////////////////////

    task automatic run_model();
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      addr;
        word_t      imm_s;
        word_t      imm_z;
        logic [5:0] op;
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] dst;
        logic       wr;
        logic       uses_b;
        logic       prev_load;
        logic [4:0] prev_rd;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        prev_load     = 1'b0;
        prev_rd       = '0;
        n_pred_stalls = 0;
        for (int i = 0; i < TOTAL; i++) begin
            ins   = imem[i];
            op    = ins[31:26];
            ra    = ins[25:21];
            rb    = ins[20:16];
            a     = model_regs[ra];
            b     = model_regs[rb];
            imm_s = {{16{ins[15]}}, ins[15:0]};
            imm_z = {16'd0, ins[15:0]};
            exp_trace.push_back(word_t'(4 * i));
            // load result not ready for the next instruction, fetch repeats once
            uses_b = (op == `DLX_OP_RTYPE) || (op == `DLX_OP_SW);
            if (prev_load && prev_rd != 0 && (prev_rd == ra || (uses_b && prev_rd == rb))) begin
                exp_trace.push_back(word_t'(4 * (i + 1)));
                n_pred_stalls++;
            end
            wr  = 1'b1;
            dst = rb;
            res = '0;
            case (op)
                `DLX_OP_RTYPE: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        `DLX_FN_ADD: res = a + b;
                        `DLX_FN_SUB: res = a - b;
                        `DLX_FN_AND: res = a & b;
                        `DLX_FN_OR:  res = a | b;
                        `DLX_FN_XOR: res = a ^ b;
                        `DLX_FN_SLL: res = a << b[4:0];
                        `DLX_FN_SRL: res = a >> b[4:0];
                        `DLX_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:     wr = 1'b0;
                    endcase
                end
                `DLX_OP_ADDI: res = a + imm_s;
                `DLX_OP_ANDI: res = a & imm_z;
                `DLX_OP_ORI:  res = a | imm_z;
                `DLX_OP_XORI: res = a ^ imm_z;
                `DLX_OP_LW: begin
                    addr = a + imm_s;
                    res  = model_dmem[addr[7:2]];
                end
                `DLX_OP_SW: begin
                    wr   = 1'b0;
                    addr = a + imm_s;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    exp_src.push_back(int'(rb));
                    model_dmem[addr[7:2]] = b;
                    if (i < PROG_LEN) n_prog_stores++;
                end
                default: wr = 1'b0;
            endcase
            // r0 stays zero
            if (wr && dst != 0) model_regs[dst] = res;
            prev_load = (op == `DLX_OP_LW);
            prev_rd   = rb;
        end
        total_stores = exp_addr.size();
    endtask

    ////////////////////////////////////////
    // data port monitor
    ////////////////////////////////////////

    // sampled mid cycle, all port values settled
    always @(negedge clk) begin
        word_t ea;
        word_t ed;
        int    src;
        if (arst_n) begin
            trace.push_back(imem_addr);
            if (dmem_we) begin
                if (exp_addr.size() == 0) begin
                    $display("data write to %h after the last expected store", dmem_addr);
                    store_errs++;
                end else begin
                    ea  = exp_addr.pop_front();
                    ed  = exp_data.pop_front();
                    src = exp_src.pop_front();
                    assert (dmem_addr == ea && dmem_wdata == ed) else begin
                        $display("ERROR %0t: store %0d wrote %h to %h, expected %h to %h",
                                 $time, stores_seen, dmem_wdata, dmem_addr, ed, ea);
                        if (stores_seen >= n_prog_stores) dump_errs++;
                        else store_errs++;
                    end
                    if (src == 0) begin
                        assert (dmem_wdata == '0) else begin
                            $display("ERROR %0t: store of r0 wrote %h", $time, dmem_wdata);
                            r0_errs++;
                        end
                    end
                    dmem[dmem_addr[7:2]] = dmem_wdata;
                    stores_seen++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    function automatic string verdict(int errs);
        return errs == 0 ? "ok" : "FAIL";
    endfunction

    initial begin
        int repeats;
        int errs;
        arst_n        = 1'b0;
        lfsr_state    = 32'hf64d1a1d;
        n_prog_stores = 0;
        stores_seen   = 0;
        timed_out     = 1'b0;
        reset_errs    = 0;
        store_errs    = 0;
        lu_errs       = 0;
        trace_errs    = 0;
        r0_errs       = 0;
        dump_errs     = 0;
        gen_program();
        run_model();

        // reset held for 5 cycles, outputs quiet throughout
        repeat (5) begin
            @(negedge clk);
            assert (dmem_we == 1'b0 && imem_addr == `DLX_RESET_PC) else begin
                $display("ERROR %0t: in reset dmem_we=%b imem_addr=%h", $time, dmem_we,
                         imem_addr);
                reset_errs++;
            end
        end
        @(posedge clk);
        #1 arst_n = 1'b1;
        @(negedge clk);
        assert (dmem_we == 1'b0 && imem_addr == `DLX_RESET_PC) else begin
            $display("ERROR %0t: after reset dmem_we=%b imem_addr=%h", $time, dmem_we,
                     imem_addr);
            reset_errs++;
        end
        $display("test reset: %s", verdict(reset_errs));

        while (stores_seen < total_stores && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        if (stores_seen < total_stores) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d stores seen after %0d cycles",
                     stores_seen, total_stores, cycles);
        end

        // fetch trace against the model, including stall repeats
        repeats = 0;
        if (trace.size() < exp_trace.size()) begin
            $display("fetch trace too short: %0d of %0d addresses", trace.size(),
                     exp_trace.size());
            trace_errs++;
        end else begin
            for (int i = 0; i < exp_trace.size(); i++) begin
                if (i > 0 && trace[i] == trace[i - 1]) repeats++;
                assert (trace[i] == exp_trace[i]) else begin
                    $display("ERROR %0t: fetch %0d at %h, expected %h", $time, i, trace[i],
                             exp_trace[i]);
                    trace_errs++;
                    break;
                end
            end
        end
        assert (n_pred_stalls > 0 && repeats == n_pred_stalls) else begin
            $display("ERROR %0t: %0d stall repeats seen, model predicts %0d", $time,
                     repeats, n_pred_stalls);
            lu_errs++;
        end

        $display("test store stream: %s", verdict(store_errs));
        $display("test load-use: %s (%0d stalls)", verdict(lu_errs), n_pred_stalls);
        $display("test fetch trace: %s", verdict(trace_errs));
        $display("test r0: %s", verdict(r0_errs));
        $display("test final dump: %s", verdict(dump_errs));
        errs = reset_errs + store_errs + lu_errs + trace_errs + r0_errs + dump_errs;
        $display("tests 6, errors %0d, stores %0d of %0d, cycles %0d", errs, stores_seen,
                 total_stores, cycles);
        if (errs == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+logic
logic/dlx_pkg.sv
logic/pipe_stage_reg.sv
logic/front_end.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/execute_unit.sv
logic/memory_stage.sv
logic/dlx_core.sv
verif/dlx_core_assert.sv
verif/dlx_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dlx_core_tb
BUILD_DIR ?= build
LOG       ?= sim.log

SRCS := $(wildcard logic/*.sv logic/*.svh verif/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) files.f
	$(VERILATOR) --binary --timing -f files.f --top-module $(TOP) -Mdir $(BUILD_DIR) -j 0

run: $(BIN)
	$(BIN) > $(LOG); status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
